/* source/alu_pkg.sv */
package alu_pkg;

    // Opcode field width on the switches
    localparam int OP_WIDTH = 6;

    // MIPS-style function codes
    typedef enum logic [OP_WIDTH-1:0] {
        ALU_ADD = 6'b100000,    // Signed add
        ALU_SUB = 6'b100010,    // Signed subtract
        ALU_AND = 6'b100100,
        ALU_OR  = 6'b100101,
        ALU_XOR = 6'b100110,
        ALU_NOR = 6'b100111,
        ALU_SRA = 6'b000011,    // Arithmetic shift right
        ALU_SRL = 6'b000010     // Logical shift right
    } alu_op_e;

    // Codes outside this list are legal on the switches.
    // The ALU maps them to a zero result.

endpackage

/* source/button_debounce.sv */
`timescale 1ns/1ps

module button_debounce #(
    parameter int DEBOUNCE_CYCLES = 1000000     // Cycles a new level must hold
) (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_button,      // Raw asynchronous level
    output logic o_press        // One-cycle pulse per accepted press
);

    // Counter runs 0 .. DEBOUNCE_CYCLES-1
    localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic             sync_meta;        // First synchronizer stage
    logic             sync_level;       // Safe to use in this clock domain
    logic             stable_level;     // Last accepted level
    logic [CNT_W-1:0] stable_cnt;       // Cycles the new level has held
    logic             level_change;

    // Two-flop synchronizer
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            sync_meta  <= 1'b0;
            sync_level <= 1'b0;
        end else begin
            sync_meta  <= i_button;
            sync_level <= sync_meta;
        end
    end

    assign level_change = (sync_level != stable_level);

    // Accept a new level only after it held for the full count
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            stable_level <= 1'b0;
            stable_cnt   <= '0;
            o_press      <= 1'b0;
        end else begin
            o_press <= 1'b0;
            if (!level_change) begin
                stable_cnt <= '0;                   // Bounce back, start over
            end else if (stable_cnt == CNT_LAST) begin
                stable_level <= sync_level;
                stable_cnt   <= '0;
                o_press      <= sync_level;         // Rising change only
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

/* source/alu_input_ctrl.sv */
`timescale 1ns/1ps

module alu_input_ctrl #(
    parameter int N = 5     // Operand width
) (
    input  logic                              i_clock,
    input  logic                              i_reset,
    input  logic [2*N+alu_pkg::OP_WIDTH-1:0]  i_sw,         // {op, B, A}
    input  logic                              i_load_a,     // Debounced press pulses
    input  logic                              i_load_b,
    input  logic                              i_load_op,
    output logic [N-1:0]                      o_alu_a,
    output logic [N-1:0]                      o_alu_b,
    output alu_pkg::alu_op_e                  o_alu_op
);

    import alu_pkg::*;

    logic [N-1:0]        sw_a;
    logic [N-1:0]        sw_b;
    logic [OP_WIDTH-1:0] sw_op;

    // Switch bus fields
    assign sw_a  = i_sw[N-1:0];
    assign sw_b  = i_sw[2*N-1:N];
    assign sw_op = i_sw[2*N +: OP_WIDTH];

    // Operand A
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_alu_a <= '0;
        end else if (i_load_a) begin
            o_alu_a <= sw_a;
        end
    end

    // Operand B
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_alu_b <= '0;
        end else if (i_load_b) begin
            o_alu_b <= sw_b;
        end
    end

    // Opcode, taken as is
    // An unlisted code still reaches the ALU, which returns zero for it
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_alu_op <= ALU_ADD;
        end else if (i_load_op) begin
            o_alu_op <= alu_op_e'(sw_op);
        end
    end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu #(
    parameter int N = 5     // Operand and result width
) (
    input  logic             i_clock,
    input  logic             i_reset,
    input  logic [N-1:0]     i_alu_a,
    input  logic [N-1:0]     i_alu_b,
    input  alu_pkg::alu_op_e i_alu_op,
    output logic [N-1:0]     o_alu_result,
    output logic             o_overflow_flag,   // Signed overflow, ADD/SUB only
    output logic             o_zero_flag
);

    import alu_pkg::*;

    logic [N-1:0] sum;
    logic [N-1:0] diff;
    logic         sum_ovf;
    logic         diff_ovf;
    logic         shift_big;        // B selects a shift of N or more
    logic [N-1:0] next_result;
    logic         next_ovf;

    assign sum  = i_alu_a + i_alu_b;
    assign diff = i_alu_a - i_alu_b;

    // Same operand signs but the sum flips sign
    assign sum_ovf = (i_alu_a[N-1] == i_alu_b[N-1]) && (sum[N-1] != i_alu_a[N-1]);

    // Opposite signs and the difference takes the sign of B
    assign diff_ovf = (i_alu_a[N-1] != i_alu_b[N-1]) && (diff[N-1] != i_alu_a[N-1]);

    assign shift_big = (i_alu_b >= N);

    always_comb begin
        next_result = '0;
        next_ovf    = 1'b0;
        case (i_alu_op)
            ALU_ADD: begin
                next_result = sum;
                next_ovf    = sum_ovf;
            end
            ALU_SUB: begin
                next_result = diff;
                next_ovf    = diff_ovf;
            end
            ALU_AND: next_result = i_alu_a & i_alu_b;
            ALU_OR:  next_result = i_alu_a | i_alu_b;
            ALU_XOR: next_result = i_alu_a ^ i_alu_b;
            ALU_NOR: next_result = ~(i_alu_a | i_alu_b);
            ALU_SRA: begin
                if (shift_big) begin
                    next_result = {N{i_alu_a[N-1]}};    // Sign fill
                end else begin
                    next_result = $signed(i_alu_a) >>> i_alu_b;
                end
            end
            ALU_SRL: begin
                if (shift_big) begin
                    next_result = '0;
                end else begin
                    next_result = i_alu_a >> i_alu_b;
                end
            end
            default: next_result = '0;      // Unknown code
        endcase
    end

    // Result and flags change on the same edge
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_alu_result    <= '0;
            o_overflow_flag <= 1'b0;
            o_zero_flag     <= 1'b1;    // Result is zero after reset
        end else begin
            o_alu_result    <= next_result;
            o_overflow_flag <= next_ovf;
            o_zero_flag     <= (next_result == '0);
        end
    end

endmodule

/* source/alu_top.sv */
`timescale 1ns/1ps

module alu_top #(
    parameter int N               = 5,          // Operand width
    parameter int DEBOUNCE_CYCLES = 1000000,    // About 10 ms at 100 MHz
    localparam int N_SW           = 2*N + alu_pkg::OP_WIDTH
) (
    input  logic            i_clock,
    input  logic            i_reset,
    input  logic [N_SW-1:0] i_switches,         // {op, B, A}
    input  logic            i_button_a,
    input  logic            i_button_b,
    input  logic            i_button_op,
    output logic [N-1:0]    o_led_result,
    output logic            o_overflow_flag,
    output logic            o_zero_flag
);

    import alu_pkg::*;

    logic         press_a;
    logic         press_b;
    logic         press_op;
    logic [N-1:0] alu_a;
    logic [N-1:0] alu_b;
    alu_op_e      alu_op;

    // One conditioner per push button
    button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_deb_a (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_button (i_button_a),
        .o_press  (press_a)
    );

    button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_deb_b (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_button (i_button_b),
        .o_press  (press_b)
    );

    button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_deb_op (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_button (i_button_op),
        .o_press  (press_op)
    );

    // Operand and opcode registers
    alu_input_ctrl #(.N(N)) u_ctrl (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_sw      (i_switches),
        .i_load_a  (press_a),
        .i_load_b  (press_b),
        .i_load_op (press_op),
        .o_alu_a   (alu_a),
        .o_alu_b   (alu_b),
        .o_alu_op  (alu_op)
    );

    // ALU outputs drive the LEDs directly
    alu #(.N(N)) u_alu (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_alu_a         (alu_a),
        .i_alu_b         (alu_b),
        .i_alu_op        (alu_op),
        .o_alu_result    (o_led_result),
        .o_overflow_flag (o_overflow_flag),
        .o_zero_flag     (o_zero_flag)
    );

endmodule

/* tb/alu_tb.sv */
`timescale 1ns/1ps

module alu_tb;

    import alu_pkg::*;

    localparam int N               = 5;
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int N_SW            = 2*N + OP_WIDTH;
    localparam int FIELDS          = 6;     // A, B, op, result, overflow, zero
    localparam int MAX_VECTORS     = 64;
    localparam int N_RANDOM        = 16;
    localparam int HOLD_CYCLES     = DEBOUNCE_CYCLES + 3;
    localparam int SETTLE_CYCLES   = DEBOUNCE_CYCLES + 2;  // Released button goes idle
    localparam int MAX_SIGNED      = (1 << (N-1)) - 1;
    localparam int MIN_SIGNED      = -(1 << (N-1));
    localparam int BTN_A           = 0;
    localparam int BTN_B           = 1;
    localparam int BTN_OP          = 2;
    // Three presses, check wait, settle and up to eight idle cycles
    localparam int VECTOR_CYCLES   = 3*(HOLD_CYCLES + 1) + 4 + SETTLE_CYCLES + 8;
    localparam int EXTRA_STEPS     = 6;     // Single presses and glitches
    localparam int RESET_MARGIN    = 50;

    logic            i_clock;
    logic            i_reset;
    logic [N_SW-1:0] i_switches;
    logic            i_button_a;
    logic            i_button_b;
    logic            i_button_op;
    logic [N-1:0]    o_led_result;
    logic            o_overflow_flag;
    logic            o_zero_flag;

    logic [7:0]  test_mem [0:(MAX_VECTORS+1)*FIELDS-1];
    logic [31:0] lfsr_state = 32'ha79b;
    int          num_vectors = 0;
    int          cycle_count = 0;
    int          timeout_limit = (MAX_VECTORS + N_RANDOM + EXTRA_STEPS) * VECTOR_CYCLES
                                 + RESET_MARGIN;

    alu_top #(.N(N), .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) uut (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_switches      (i_switches),
        .i_button_a      (i_button_a),
        .i_button_b      (i_button_b),
        .i_button_op     (i_button_op),
        .o_led_result    (o_led_result),
        .o_overflow_flag (o_overflow_flag),
        .o_zero_flag     (o_zero_flag)
    );

    initial begin
        i_clock = 1'b0;
        forever #10 i_clock = ~i_clock;     // 20 ns period
    end

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run still going after %0d clock cycles", cycle_count);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at %0d ns", $time);
    endtask

    task automatic check_result(input logic [N-1:0] expected, input logic [N-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: o_led_result expected %h, got %h",
                     $time, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input logic expected, input logic actual, input string name);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic take_bits(input int count, output logic [7:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[6:0], lfsr_state[0]};
        end
    endtask

    function automatic int to_signed_int(input logic [N-1:0] value);
        if (value[N-1]) begin
            return int'(value) - (1 << N);
        end
        return int'(value);
    endfunction

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge i_clock);
    endtask

    task automatic drive_button(input int which, input logic level);
        case (which)
            BTN_A:   i_button_a  <= level;
            BTN_B:   i_button_b  <= level;
            default: i_button_op <= level;
        endcase
    endtask

    // Raise one button for hold cycles, then let it go
    task automatic press_button(input int which, input int hold);
        @(posedge i_clock);
        drive_button(which, 1'b1);
        wait_cycles(hold);
        drive_button(which, 1'b0);
    endtask

    task automatic set_switches(input logic [N-1:0] a, input logic [N-1:0] b,
                                input logic [OP_WIDTH-1:0] op);
        @(posedge i_clock);
        i_switches <= {op, b, a};
    endtask

    task automatic check_outputs(input logic [N-1:0] exp_res, input logic exp_ovf,
                                 input logic exp_zero);
        @(negedge i_clock);
        check_result(exp_res, o_led_result);
        check_flag(exp_ovf, o_overflow_flag, "o_overflow_flag");
        check_flag(exp_zero, o_zero_flag, "o_zero_flag");
    endtask

    task automatic run_vector(input logic [N-1:0] a, input logic [N-1:0] b,
                              input logic [OP_WIDTH-1:0] op, input logic [N-1:0] exp_res,
                              input logic exp_ovf, input logic exp_zero);
        set_switches(a, b, op);
        press_button(BTN_A, HOLD_CYCLES);
        press_button(BTN_B, HOLD_CYCLES);
        press_button(BTN_OP, HOLD_CYCLES);
        wait_cycles(3);     // DEBOUNCE_CYCLES+6 edges after Op rose
        check_outputs(exp_res, exp_ovf, exp_zero);
        wait_cycles(SETTLE_CYCLES);
    endtask

    // Loads one field only, the other registers keep their values
    task automatic run_single_press(input int which, input logic [N-1:0] a,
                                    input logic [N-1:0] b, input logic [OP_WIDTH-1:0] op,
                                    input logic [N-1:0] exp_res, input logic exp_ovf,
                                    input logic exp_zero);
        set_switches(a, b, op);
        press_button(which, HOLD_CYCLES);
        wait_cycles(3);
        check_outputs(exp_res, exp_ovf, exp_zero);
        wait_cycles(SETTLE_CYCLES);
    endtask

    task automatic run_glitches(input logic [N-1:0] a, input logic [N-1:0] b,
                                input logic [OP_WIDTH-1:0] op, input logic [N-1:0] held_res,
                                input logic held_ovf, input logic held_zero);
        set_switches(a, b, op);
        press_button(BTN_A, DEBOUNCE_CYCLES - 1);
        press_button(BTN_B, DEBOUNCE_CYCLES - 1);
        press_button(BTN_OP, DEBOUNCE_CYCLES - 1);
        wait_cycles(DEBOUNCE_CYCLES + 6);
        check_outputs(held_res, held_ovf, held_zero);
    endtask

    // Signed sum in integer range, then truncated
    task automatic run_random_add(input logic [N-1:0] a, input logic [N-1:0] b);
        int           sum;
        logic [N-1:0] exp_res;
        logic         exp_ovf;
        sum     = to_signed_int(a) + to_signed_int(b);
        exp_res = sum[N-1:0];
        exp_ovf = (sum > MAX_SIGNED) || (sum < MIN_SIGNED);
        run_vector(a, b, ALU_ADD, exp_res, exp_ovf, exp_res == '0);
    endtask

    task automatic load_vectors();
        int k;
        int count_pos;
        count_pos = -1;
        for (k = 0; k < (MAX_VECTORS+1)*FIELDS; k++) begin
            test_mem[k] = 8'hff;    // Never a legal field value
        end
        $readmemh("tb/alu_testdata.txt", test_mem);
        // Count line sits where the next vector would start
        for (k = 0; k <= MAX_VECTORS && count_pos < 0; k++) begin
            if (test_mem[FIELDS*k+1] == 8'hff) begin
                count_pos = k;
            end
        end
        if (count_pos <= 0) begin
            $display("Test data file is missing, empty or holds too many vectors");
            stop_with_failure();
        end
        if (int'(test_mem[FIELDS*count_pos]) != count_pos) begin
            $display("Test data count line does not match the %0d vectors found", count_pos);
            stop_with_failure();
        end
        num_vectors = count_pos;
    endtask

    initial begin
        int         k;
        logic [7:0] idle;
        logic [7:0] rand_a;
        logic [7:0] rand_b;
        i_reset     = 1'b1;
        i_switches  = '0;
        i_button_a  = 1'b0;
        i_button_b  = 1'b0;
        i_button_op = 1'b0;
        load_vectors();
        timeout_limit = (num_vectors + N_RANDOM + EXTRA_STEPS) * VECTOR_CYCLES + RESET_MARGIN;
        wait_cycles(3);
        i_reset <= 1'b0;
        check_outputs({N{1'b0}}, 1'b0, 1'b1);

        for (k = 0; k < num_vectors; k++) begin
            run_vector(test_mem[FIELDS*k][N-1:0], test_mem[FIELDS*k+1][N-1:0],
                       test_mem[FIELDS*k+2][OP_WIDTH-1:0], test_mem[FIELDS*k+3][N-1:0],
                       test_mem[FIELDS*k+4][0], test_mem[FIELDS*k+5][0]);
            take_bits(3, idle);
            wait_cycles(int'(idle));
        end
        $display("%0d vectors from the data file checked", num_vectors);

        // Known state, then one field at a time
        run_vector(5'h05, 5'h09, ALU_ADD, 5'h0e, 1'b0, 1'b0);
        run_single_press(BTN_OP, 5'h1e, 5'h1e, ALU_SUB, 5'h1c, 1'b0, 1'b0);    // 5 - 9
        run_single_press(BTN_A, 5'h02, 5'h1c, ALU_AND, 5'h19, 1'b0, 1'b0);     // 2 - 9
        run_single_press(BTN_B, 5'h11, 5'h0a, ALU_OR, 5'h18, 1'b0, 1'b0);      // 2 - 10

        // Short presses with new switch values change nothing
        run_glitches(5'h05, 5'h03, ALU_ADD, 5'h18, 1'b0, 1'b0);

        for (k = 0; k < N_RANDOM; k++) begin
            take_bits(N, rand_a);
            take_bits(N, rand_b);
            run_random_add(rand_a[N-1:0], rand_b[N-1:0]);
            take_bits(3, idle);
            wait_cycles(int'(idle));
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* tb/alu_testdata.txt */
// Columns in hex: A B opcode result overflow zero
// Last line is the number of vectors
// ADD, signed overflow both ways
03 04 20 07 0 0
0f 01 20 10 1 0
10 10 20 00 1 1
1f 01 20 00 0 1
18 1c 20 14 0 0
11 1e 20 0f 1 0
// SUB
07 03 22 04 0 0
03 07 22 1c 0 0
10 01 22 0f 1 0
0f 1f 22 10 1 0
05 05 22 00 0 1
1f 0f 22 10 0 0
// AND, OR
1c 0e 24 0c 0 0
15 0a 24 00 0 1
15 0a 25 1f 0 0
00 00 25 00 0 1
10 03 25 13 0 0
// XOR, NOR
1f 0f 26 10 0 0
0b 0b 26 00 0 1
0f 01 26 0e 0 0
00 00 27 1f 0 0
15 0a 27 00 0 1
0c 03 27 10 0 0
// SRA, including shifts of N or more
10 02 03 1c 0 0
0c 02 03 03 0 0
14 05 03 1f 0 0
0a 1f 03 00 0 1
1b 00 03 1b 0 0
11 04 03 1f 0 0
// SRL, including shifts of N or more
10 02 02 04 0 0
1f 04 02 01 0 0
1f 05 02 00 0 1
1f 1e 02 00 0 1
16 01 02 0b 0 0
// Unknown codes give zero
0f 01 3f 00 0 1
0f 01 00 00 0 1
1f 1f 21 00 0 1
// Back to ADD
07 08 20 0f 0 0
26

/* files.f */
source/alu_pkg.sv
source/button_debounce.sv
source/alu_input_ctrl.sv
source/alu.sv
source/alu_top.sv
tb/alu_tb.sv

/* Makefile */
# Verilator build and run for the ALU testbench

VERILATOR       ?= verilator
TOP             ?= alu_tb
FILE_LIST       ?= files.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing -Wno-fatal
PASS_MSG        ?= Simulation finished: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Passes only when the simulation output holds the pass message
run: compile
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qF "$(PASS_MSG)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
